// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_weight_top_buffer
FILELIST  = weight_top_buffer.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/weight_bank_ram.sv ====
`timescale 1ns/1ps

module weight_bank_ram
        import weight_geom_pkg::*;
#(
        parameter int ADDR_W = 8
) (
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    wr_en,
        input  logic [ADDR_W-1:0]       wr_addr,
        input  logic [WORD_W-1:0]       wr_data,
        input  logic [ADDR_W-1:0]       rd_addr,
        output logic [WORD_W-1:0]       rd_data
);

        localparam int DEPTH = 1 << ADDR_W;

        logic [WORD_W-1:0] mem [0:DEPTH-1];

        always_ff @(posedge sclk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // Read during write returns the old word
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        rd_data <= '0;
                end else begin
                        rd_data <= mem[rd_addr];
                end
        end

endmodule

// ==== hw/weight_ctrl_pkg.sv ====
package weight_ctrl_pkg;

        // conv_type encodings
        localparam logic CONV_3X3 = 1'b0;
        localparam logic CONV_1X1 = 1'b1;

        // Sequencing counter widths
        localparam int TAP_CNT_W  = 4;
        localparam int BANK_CNT_W = 3;

endpackage

// ==== hw/weight_geom_pkg.sv ====
package weight_geom_pkg;

        //==========================================================
        // Stream and kernel geometry
        //==========================================================

        // Input lanes with one byte each per beat
        localparam int LANES    = 8;
        // Bytes in one 3x3 kernel
        localparam int TAPS     = 9;
        // Output-channel banks behind every lane
        localparam int BANKS    = 8;
        localparam int BYTE_W   = 8;
        localparam int WORD_W   = TAPS * BYTE_W;
        localparam int STREAM_W = LANES * BYTE_W;

endpackage

// ==== hw/weight_single_buffer.sv ====
`timescale 1ns/1ps

module weight_single_buffer
        import weight_geom_pkg::*, weight_ctrl_pkg::*;
#(
        parameter int ADDR_W = 8
) (
        input  logic                            sclk,
        input  logic                            s_rst_n,
        input  logic                            weight_data_in_vld,
        input  logic [BYTE_W-1:0]               lane_byte,
        input  logic                            conv_type,
        input  logic [TAP_CNT_W-1:0]            tap_cnt,
        input  logic                            wr_en,
        input  logic [BANK_CNT_W-1:0]           bank_cnt,
        input  logic [ADDR_W-1:0]               wr_addr,
        input  logic [ADDR_W-1:0]               wbuffer_rd_addr,
        output logic [BANKS*WORD_W-1:0]         bank_words
);

        logic [WORD_W-1:0]      kernel_word;
        logic [BANKS-1:0]       bank_wr_en;

        //==========================================================
        // Kernel word assembly
        //==========================================================
        always_ff @(posedge sclk) begin
                if (weight_data_in_vld) begin
                        if (conv_type == CONV_1X1) begin
                                // Single tap with the upper taps forced to zero
                                kernel_word <= {{(WORD_W - BYTE_W){1'b0}}, lane_byte};
                        end else begin
                                for (int t = 0; t < TAPS; t++) begin
                                        if (tap_cnt == TAP_CNT_W'(t)) begin
                                                kernel_word[t*BYTE_W +: BYTE_W] <= lane_byte;
                                        end
                                end
                        end
                end
        end

        //==========================================================
        // Output-channel banks
        //==========================================================
        for (genvar b = 0; b < BANKS; b++) begin : g_bank
                // One-hot bank select from the shared round-robin count
                assign bank_wr_en[b] = wr_en && (bank_cnt == BANK_CNT_W'(b));

                weight_bank_ram #(
                        .ADDR_W         (ADDR_W)
                ) u_bank_ram (
                        .sclk           (sclk),
                        .s_rst_n        (s_rst_n),
                        .wr_en          (bank_wr_en[b]),
                        .wr_addr        (wr_addr),
                        .wr_data        (kernel_word),
                        .rd_addr        (wbuffer_rd_addr),
                        .rd_data        (bank_words[b*WORD_W +: WORD_W])
                );
        end

endmodule

// ==== hw/weight_top_buffer.sv ====
`timescale 1ns/1ps

module weight_top_buffer
        import weight_geom_pkg::*, weight_ctrl_pkg::*;
#(
        parameter int ADDR_W = 8
) (
        input  logic                                    sclk,
        input  logic                                    s_rst_n,
        input  logic [STREAM_W-1:0]                     weight_data_in,
        input  logic                                    weight_data_in_vld,
        input  logic                                    store_start,
        input  logic                                    conv_type,
        input  logic [ADDR_W-1:0]                       wbuffer_rd_addr,
        output logic [LANES*BANKS*WORD_W-1:0]           weight_3x3
);

        logic [TAP_CNT_W-1:0]   tap_cnt;
        logic                   wr_en;
        logic [BANK_CNT_W-1:0]  bank_cnt;
        logic [ADDR_W-1:0]      wr_addr;

        // Sequencing shared by all lanes
        weight_wr_ctrl #(
                .ADDR_W                 (ADDR_W)
        ) u_wr_ctrl (
                .sclk                   (sclk),
                .s_rst_n                (s_rst_n),
                .weight_data_in_vld     (weight_data_in_vld),
                .conv_type              (conv_type),
                .store_start            (store_start),
                .tap_cnt                (tap_cnt),
                .wr_en                  (wr_en),
                .bank_cnt               (bank_cnt),
                .wr_addr                (wr_addr)
        );

        //==========================================================
        // Lane buffers where lane k takes byte k of the stream
        //==========================================================
        for (genvar l = 0; l < LANES; l++) begin : g_lane
                weight_single_buffer #(
                        .ADDR_W                 (ADDR_W)
                ) u_single_buffer (
                        .sclk                   (sclk),
                        .s_rst_n                (s_rst_n),
                        .weight_data_in_vld     (weight_data_in_vld),
                        .lane_byte              (weight_data_in[l*BYTE_W +: BYTE_W]),
                        .conv_type              (conv_type),
                        .tap_cnt                (tap_cnt),
                        .wr_en                  (wr_en),
                        .bank_cnt               (bank_cnt),
                        .wr_addr                (wr_addr),
                        .wbuffer_rd_addr        (wbuffer_rd_addr),
                        .bank_words             (weight_3x3[l*BANKS*WORD_W +: BANKS*WORD_W])
                );
        end

endmodule

// ==== hw/weight_wr_ctrl.sv ====
`timescale 1ns/1ps

module weight_wr_ctrl
        import weight_geom_pkg::*, weight_ctrl_pkg::*;
#(
        parameter int ADDR_W = 8
) (
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    weight_data_in_vld,
        input  logic                    conv_type,
        input  logic                    store_start,
        output logic [TAP_CNT_W-1:0]    tap_cnt,
        output logic                    wr_en,
        output logic [BANK_CNT_W-1:0]   bank_cnt,
        output logic [ADDR_W-1:0]       wr_addr
);

        localparam logic [TAP_CNT_W-1:0]  TAP_LAST  = TAP_CNT_W'(TAPS - 1);
        localparam logic [BANK_CNT_W-1:0] BANK_LAST = BANK_CNT_W'(BANKS - 1);

        logic beat_3x3;
        logic word_done;
        logic bank_wrap;

        assign beat_3x3  = weight_data_in_vld && (conv_type == CONV_3X3);
        // Last tap of a kernel, or any byte in 1x1 mode
        assign word_done = (beat_3x3 && (tap_cnt == TAP_LAST)) ||
                           (weight_data_in_vld && (conv_type == CONV_1X1));
        assign bank_wrap = wr_en && (bank_cnt == BANK_LAST);

        //==========================================================
        // Tap counter for 3x3 mode only
        //==========================================================
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        tap_cnt <= '0;
                end else if (beat_3x3) begin
                        if (tap_cnt == TAP_LAST) begin
                                tap_cnt <= '0;
                        end else begin
                                tap_cnt <= tap_cnt + 1'b1;
                        end
                end
        end

        // Write pulse lands one cycle after the completing beat
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        wr_en <= 1'b0;
                end else begin
                        wr_en <= word_done;
                end
        end

        //==========================================================
        // Bank round-robin and shared write address
        //==========================================================
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        bank_cnt <= '0;
                end else if (bank_wrap) begin
                        bank_cnt <= '0;
                end else if (wr_en) begin
                        bank_cnt <= bank_cnt + 1'b1;
                end
        end

        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        wr_addr <= '0;
                end else if (store_start) begin
                        wr_addr <= '0;
                end else if (bank_wrap) begin
                        wr_addr <= wr_addr + 1'b1;
                end
        end

endmodule

// ==== testbench/tb_weight_top_buffer.sv ====
`timescale 1ns/1ps

module tb_weight_top_buffer
        import weight_geom_pkg::*, weight_ctrl_pkg::*;
();

        localparam int ADDR_W       = 4;
        localparam int DEPTH        = 1 << ADDR_W;
        localparam int CLK_PERIOD   = 4;
        localparam int RESET_CYCLES = 16;
        localparam int GROUP_BEATS  = BANKS * TAPS;
        localparam int MAX_GAP      = 3;
        // Five kernel groups at worst-case gaps, sweeps and idle time on top
        localparam int RUN_CYCLES   = RESET_CYCLES + 5 * GROUP_BEATS * (MAX_GAP + 1) + 400;

        logic                           sclk;
        logic                           s_rst_n;
        logic [STREAM_W-1:0]            weight_data_in;
        logic                           weight_data_in_vld;
        logic                           store_start;
        logic                           conv_type;
        logic [ADDR_W-1:0]              wbuffer_rd_addr;
        logic [LANES*BANKS*WORD_W-1:0]  weight_3x3;

        // Reference model indexed by address, bank and lane
        logic [WORD_W-1:0]              model [0:DEPTH-1][0:BANKS-1][0:LANES-1];
        logic [WORD_W-1:0]              kernel [0:LANES-1];
        int                             m_tap;
        int                             m_bank;
        int                             m_addr;
        logic                           cur_mode;
        logic [STREAM_W-1:0]            beats [$];
        logic                           rd_chk;
        logic [LANES*BANKS*WORD_W-1:0]  exp_flat;
        integer                         seed;
        int                             rd_err_cnt;

        weight_top_buffer #(
                .ADDR_W                 (ADDR_W)
        ) UUT (
                .sclk                   (sclk),
                .s_rst_n                (s_rst_n),
                .weight_data_in         (weight_data_in),
                .weight_data_in_vld     (weight_data_in_vld),
                .store_start            (store_start),
                .conv_type              (conv_type),
                .wbuffer_rd_addr        (wbuffer_rd_addr),
                .weight_3x3             (weight_3x3)
        );

        always #(CLK_PERIOD / 2) sclk = ~sclk;

        // Model view of one address in the weight_3x3 layout
        function automatic logic [LANES*BANKS*WORD_W-1:0] expected_flat(input int addr);
                logic [LANES*BANKS*WORD_W-1:0] flat;
                flat = '0;
                for (int l = 0; l < LANES; l++) begin
                        for (int b = 0; b < BANKS; b++) begin
                                flat[(l*BANKS+b)*WORD_W +: WORD_W] = model[addr][b][l];
                        end
                end
                return flat;
        endfunction

        task automatic model_beat(input logic [STREAM_W-1:0] data);
                for (int l = 0; l < LANES; l++) begin
                        if (cur_mode == CONV_1X1) begin
                                kernel[l] = {{(WORD_W - BYTE_W){1'b0}}, data[l*BYTE_W +: BYTE_W]};
                        end else begin
                                kernel[l][m_tap*BYTE_W +: BYTE_W] = data[l*BYTE_W +: BYTE_W];
                        end
                end
                if ((cur_mode == CONV_1X1) || (m_tap == TAPS - 1)) begin
                        for (int l = 0; l < LANES; l++) begin
                                model[m_addr][m_bank][l] = kernel[l];
                        end
                        m_bank = (m_bank + 1) % BANKS;
                        if (m_bank == 0) begin
                                m_addr = (m_addr + 1) % DEPTH;
                        end
                end
                if (cur_mode == CONV_3X3) begin
                        m_tap = (m_tap + 1) % TAPS;
                end
        endtask

        task automatic fill_beats(input int count);
                beats.delete();
                repeat (count) begin
                        beats.push_back({$random(seed), $random(seed)});
                end
        endtask

        // Idle cycles carry random bytes that must be ignored
        task automatic send_beats(input bit with_gaps);
                int n_gap;
                foreach (beats[i]) begin
                        if (with_gaps) begin
                                n_gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                                repeat (n_gap) begin
                                        @(posedge sclk);
                                        weight_data_in     <= {$random(seed), $random(seed)};
                                        weight_data_in_vld <= 1'b0;
                                end
                        end
                        @(posedge sclk);
                        weight_data_in     <= beats[i];
                        weight_data_in_vld <= 1'b1;
                        model_beat(beats[i]);
                end
                @(posedge sclk);
                weight_data_in_vld <= 1'b0;
                repeat (3) @(posedge sclk);
        endtask

        task automatic set_mode(input logic mode);
                @(posedge sclk);
                conv_type <= mode;
                cur_mode = mode;
        endtask

        task automatic restart_store();
                @(posedge sclk);
                store_start <= 1'b1;
                @(posedge sclk);
                store_start <= 1'b0;
                m_addr = 0;
        endtask

        task automatic read_sweep(input int last);
                for (int a = 0; a <= last; a++) begin
                        @(posedge sclk);
                        wbuffer_rd_addr <= ADDR_W'(a);
                        rd_chk          <= 1'b1;
                end
                @(posedge sclk);
                rd_chk <= 1'b0;
                repeat (2) @(posedge sclk);
        endtask

        always @(posedge sclk) begin
                exp_flat <= expected_flat(int'(wbuffer_rd_addr));
        end

        a_readback: assert property (@(posedge sclk) disable iff (!s_rst_n)
                        rd_chk |=> weight_3x3 == exp_flat)
                else begin
                        rd_err_cnt++;
                        $error("Mismatch weight_3x3 got %h expected %h",
                               $sampled(weight_3x3), $sampled(exp_flat));
                end

        //==========================================================
        // Test sequence
        //==========================================================
        initial begin
                int total_err;
                seed               = 32'h1acd_2e8e;
                sclk               = 1'b0;
                s_rst_n            = 1'b1;
                weight_data_in     = '0;
                weight_data_in_vld = 1'b0;
                store_start        = 1'b0;
                conv_type          = CONV_3X3;
                wbuffer_rd_addr    = '0;
                rd_chk             = 1'b0;
                rd_err_cnt         = 0;
                cur_mode           = CONV_3X3;
                m_tap              = 0;
                m_bank             = 0;
                m_addr             = 0;
                #1;
                s_rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge sclk);
                s_rst_n <= 1'b1;
                repeat (2) @(posedge sclk);

                // Two back-to-back 3x3 groups into addresses 0 and 1
                fill_beats(GROUP_BEATS);
                send_beats(1'b0);
                read_sweep(0);
                fill_beats(GROUP_BEATS);
                send_beats(1'b0);
                read_sweep(1);

                // Same bytes with and without gaps into addresses 2 and 3
                fill_beats(GROUP_BEATS);
                send_beats(1'b1);
                send_beats(1'b0);
                read_sweep(3);

                // 1x1 mode over address 0
                restart_store();
                set_mode(CONV_1X1);
                fill_beats(BANKS);
                send_beats(1'b0);
                read_sweep(0);

                // Restart in 3x3 mode with address 1 left untouched
                restart_store();
                set_mode(CONV_3X3);
                fill_beats(GROUP_BEATS);
                send_beats(1'b0);
                read_sweep(3);

                repeat (4) @(posedge sclk);
                total_err = rd_err_cnt + UUT.u_checker.fail_cnt;
                $display("Readback errors: %0d, checker errors: %0d",
                         rd_err_cnt, UUT.u_checker.fail_cnt);
                if (total_err == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

        initial begin
                #(RUN_CYCLES * CLK_PERIOD);
                $display("Timeout: the run did not finish within %0d clock cycles", RUN_CYCLES);
                $display("Something failed");
                $finish;
        end

endmodule

// ==== testbench/weight_top_buffer_checker.sv ====
`timescale 1ns/1ps

module weight_top_buffer_checker
        import weight_geom_pkg::*, weight_ctrl_pkg::*;
#(
        parameter int ADDR_W = 8
) (
        input  logic                                    sclk,
        input  logic                                    s_rst_n,
        input  logic [ADDR_W-1:0]                       wbuffer_rd_addr,
        input  logic                                    wr_en,
        input  logic [BANK_CNT_W-1:0]                   bank_cnt,
        input  logic [LANES*BANKS*WORD_W-1:0]           weight_3x3
);

        localparam logic [BANK_CNT_W-1:0] BANK_LAST = BANK_CNT_W'(BANKS - 1);

        int     fail_cnt = 0;
        logic   loaded;

        // Set once the first address holds a word in every bank
        always_ff @(posedge sclk or negedge s_rst_n) begin
                if (!s_rst_n) begin
                        loaded <= 1'b0;
                end else if (wr_en && (bank_cnt == BANK_LAST)) begin
                        loaded <= 1'b1;
                end
        end

        //==========================================================
        // Reset behavior
        //==========================================================
        a_zero_in_reset: assert property (@(posedge sclk) !s_rst_n |-> weight_3x3 == '0)
                else begin
                        fail_cnt++;
                        $error("Mismatch weight_3x3 in reset got %h expected 0",
                               $sampled(weight_3x3));
                end

        a_zero_after_reset: assert property (@(posedge sclk) $rose(s_rst_n) |-> weight_3x3 == '0)
                else begin
                        fail_cnt++;
                        $error("Mismatch weight_3x3 after reset got %h expected 0",
                               $sampled(weight_3x3));
                end

        //==========================================================
        // Output behavior
        //==========================================================
        a_no_unknown: assert property (@(posedge sclk) disable iff (!s_rst_n)
                        loaded |=> !$isunknown(weight_3x3))
                else begin
                        fail_cnt++;
                        $error("weight_3x3 holds unknown bits after the first address was filled");
                end

        // Same address and no write since the last read
        a_stable_read: assert property (@(posedge sclk) disable iff (!s_rst_n)
                        $past(s_rst_n) && $stable(wbuffer_rd_addr) && !$past(wr_en)
                        |=> $stable(weight_3x3))
                else begin
                        fail_cnt++;
                        $error("weight_3x3 changed while the read address and memory stood still");
                end

endmodule

bind weight_top_buffer weight_top_buffer_checker #(
        .ADDR_W                 (ADDR_W)
) u_checker (
        .sclk                   (sclk),
        .s_rst_n                (s_rst_n),
        .wbuffer_rd_addr        (wbuffer_rd_addr),
        .wr_en                  (wr_en),
        .bank_cnt               (bank_cnt),
        .weight_3x3             (weight_3x3)
);

// ==== weight_top_buffer.f ====
hw/weight_geom_pkg.sv
hw/weight_ctrl_pkg.sv
hw/weight_wr_ctrl.sv
hw/weight_bank_ram.sv
hw/weight_single_buffer.sv
hw/weight_top_buffer.sv
testbench/weight_top_buffer_checker.sv
testbench/tb_weight_top_buffer.sv
